// ==== src/rp_bus_pkg.sv ====
package rp_bus_pkg;

  // request from the bus master, strobes are single cycle
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        wen;    // write strobe
    logic        ren;    // read strobe
  } sys_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
    logic        ack;
  } sys_rsp_t;

  // region field sits at addr[22:20]
  localparam int unsigned region_lsb_c  = 20;
  localparam int unsigned region_bits_c = 3;
  localparam int unsigned num_regions_c = 8;

  localparam logic [region_bits_c-1:0] region_hk_c  = 3'd0;
  localparam logic [region_bits_c-1:0] region_dsp_c = 3'd3;

  localparam int unsigned reg_off_bits_c = 8;

  //////////////////////////////////////////////////
  // housekeeping map
  localparam logic [reg_off_bits_c-1:0] hk_id_off_c   = 8'h00;
  localparam logic [reg_off_bits_c-1:0] hk_loop_off_c = 8'h04;
  localparam logic [reg_off_bits_c-1:0] hk_led_off_c  = 8'h08;
  localparam logic [reg_off_bits_c-1:0] hk_exp_off_c  = 8'h0C;
  localparam logic [31:0]               hk_id_c       = 32'h5250_0001;

  //////////////////////////////////////////////////
  // dsp routing map
  localparam logic [reg_off_bits_c-1:0] dsp_sel_a_off_c  = 8'h00;
  localparam logic [reg_off_bits_c-1:0] dsp_sel_b_off_c  = 8'h04;
  localparam logic [reg_off_bits_c-1:0] dsp_offs_a_off_c = 8'h08;
  localparam logic [reg_off_bits_c-1:0] dsp_offs_b_off_c = 8'h0C;
  localparam logic [reg_off_bits_c-1:0] dsp_setp_a_off_c = 8'h10;
  localparam logic [reg_off_bits_c-1:0] dsp_setp_b_off_c = 8'h14;

endpackage

// ==== src/rp_analog_pkg.sv ====
package rp_analog_pkg;

  localparam int unsigned adc_in_bits_c = 16;  // raw port, 2 lsbs unused
  localparam int unsigned smp_bits_c    = 14;

  // internal sample, two's complement
  typedef logic signed [smp_bits_c-1:0] sample_t;
  // converter code, offset binary with negative slope
  typedef logic [smp_bits_c-1:0] raw_t;

  // dsp source per dac channel
  typedef enum logic [1:0] {
    src_adc_a = 2'd0,
    src_adc_b = 2'd1,
    src_setp  = 2'd2,
    src_zero  = 2'd3
  } src_sel_t;

  typedef struct packed {
    src_sel_t sel;
    sample_t  offs;   // signed offset, saturating add
    sample_t  setp;   // constant source
  } ch_cfg_t;

  typedef struct packed {
    sample_t a;
    sample_t b;
  } smp_pair_t;

endpackage

// ==== src/rp_bus_decoder.sv ====
module rp_bus_decoder (
  input  rp_bus_pkg::sys_req_t req_i,
  input  rp_bus_pkg::sys_rsp_t hk_rsp_i,
  input  rp_bus_pkg::sys_rsp_t dsp_rsp_i,
  output rp_bus_pkg::sys_rsp_t rsp_o,
  output rp_bus_pkg::sys_req_t hk_req_o,
  output rp_bus_pkg::sys_req_t dsp_req_o
);

  import rp_bus_pkg::*;

  logic [region_bits_c-1:0] region;  // addr[22:20]
  logic [num_regions_c-1:0] cs;      // one-hot chip select

  assign region = req_i.addr[region_lsb_c +: region_bits_c];
  assign cs     = {{(num_regions_c-1){1'b0}}, 1'b1} << region;

  //////////////////////////////////////////////////
  // request fan-out

  // addr and wdata go everywhere, strobes only to the selected slave
  always_comb
  begin
    hk_req_o     = req_i;
    hk_req_o.wen = req_i.wen & cs[region_hk_c];
    hk_req_o.ren = req_i.ren & cs[region_hk_c];
  end

  always_comb
  begin
    dsp_req_o     = req_i;
    dsp_req_o.wen = req_i.wen & cs[region_dsp_c];
    dsp_req_o.ren = req_i.ren & cs[region_dsp_c];
  end

  //////////////////////////////////////////////////
  // response mux

  always_comb
  begin
    case (region)
      region_hk_c:  rsp_o = hk_rsp_i;
      region_dsp_c: rsp_o = dsp_rsp_i;
      // empty regions, ack is a level so no slave timing applies
      default:      rsp_o = '{rdata: '0, err: 1'b0, ack: 1'b1};
    endcase
  end

endmodule

// ==== src/rp_housekeeping.sv ====
module rp_housekeeping (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  rp_bus_pkg::sys_req_t req_i,
  input  logic [7:0]           exp_i,     // expansion pins, async to us
  output rp_bus_pkg::sys_rsp_t rsp_o,
  output logic [7:0]           led_o,
  output logic                 loop_o     // digital loop enable
);

  import rp_bus_pkg::*;

  logic [reg_off_bits_c-1:0] off;
  logic                      stb;
  logic                      hit;        // offset is mapped
  logic [31:0]               rd_data;

  logic [7:0]  led_q;
  logic        loop_q;
  logic [7:0]  exp_q;
  logic        ack_q;
  logic        err_q;
  logic [31:0] rdata_q;

  assign off = req_i.addr[reg_off_bits_c-1:0];
  assign stb = req_i.wen | req_i.ren;

  //////////////////////////////////////////////////
  // read decode

  always_comb
  begin
    hit     = 1'b1;
    rd_data = '0;
    case (off)
      hk_id_off_c:   rd_data = hk_id_c;
      hk_loop_off_c: rd_data = {31'b0, loop_q};
      hk_led_off_c:  rd_data = {24'b0, led_q};
      hk_exp_off_c:  rd_data = {24'b0, exp_q};
      default:       hit = 1'b0;  // rdata stays 0
    endcase
  end

  //////////////////////////////////////////////////
  // registers

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      led_q  <= '0;
      loop_q <= 1'b0;
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
    end
    else
    begin
      ack_q <= stb;          // one cycle after strobe
      err_q <= stb & ~hit;
      if (req_i.wen)
      begin
        case (off)
          hk_loop_off_c: loop_q <= req_i.wdata[0];
          hk_led_off_c:  led_q  <= req_i.wdata[7:0];
          default:       ;   // id and exp are read only
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    exp_q   <= exp_i;        // single sample stage for readback
    rdata_q <= req_i.ren ? rd_data : '0;
  end

  assign rsp_o  = '{rdata: rdata_q, err: err_q, ack: ack_q};
  assign led_o  = led_q;
  assign loop_o = loop_q;

endmodule

// ==== src/rp_analog.sv ====
module rp_analog (
  input  logic                                    adc_clk,
  input  logic                                    rst_n_i,
  input  logic [rp_analog_pkg::adc_in_bits_c-1:0] adc_dat_a_i,
  input  logic [rp_analog_pkg::adc_in_bits_c-1:0] adc_dat_b_i,
  input  logic                                    loop_i,
  input  rp_analog_pkg::smp_pair_t                dsp_i,
  output rp_analog_pkg::smp_pair_t                adc_o,
  output rp_analog_pkg::raw_t                     dac_dat_a_o,
  output rp_analog_pkg::raw_t                     dac_dat_b_o
);

  import rp_analog_pkg::*;

  raw_t adc_raw_a;   // input registers, upper 14 bits
  raw_t adc_raw_b;
  raw_t dac_q_a;
  raw_t dac_q_b;

  // neg-slope offset binary <-> two's complement, same in both directions
  function automatic logic [smp_bits_c-1:0] neg_slope(input logic [smp_bits_c-1:0] x);
    return {x[smp_bits_c-1], ~x[smp_bits_c-2:0]};
  endfunction

  //////////////////////////////////////////////////
  // adc side

  always_ff @(posedge adc_clk)
  begin
    adc_raw_a <= adc_dat_a_i[adc_in_bits_c-1 -: smp_bits_c];  // drop 2 lsbs
    adc_raw_b <= adc_dat_b_i[adc_in_bits_c-1 -: smp_bits_c];
  end

  // digital loop replaces the converter samples with the dsp outputs
  always_comb
  begin
    adc_o.a = loop_i ? dsp_i.a : sample_t'(neg_slope(adc_raw_a));
    adc_o.b = loop_i ? dsp_i.b : sample_t'(neg_slope(adc_raw_b));
  end

  //////////////////////////////////////////////////
  // dac side

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_q_a <= neg_slope('0);  // 0x1FFF, midscale
      dac_q_b <= neg_slope('0);
    end
    else
    begin
      dac_q_a <= neg_slope(dsp_i.a);
      dac_q_b <= neg_slope(dsp_i.b);
    end
  end

  assign dac_dat_a_o = dac_q_a;
  assign dac_dat_b_o = dac_q_b;

endmodule

// ==== src/rp_dsp_route.sv ====
module rp_dsp_route (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  rp_bus_pkg::sys_req_t     req_i,
  input  rp_analog_pkg::smp_pair_t adc_i,
  output rp_bus_pkg::sys_rsp_t     rsp_o,
  output rp_analog_pkg::smp_pair_t dsp_o
);

  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  localparam int unsigned pad_c = 32 - smp_bits_c;  // readback zero fill

  logic [reg_off_bits_c-1:0] off;
  logic                      stb;
  logic                      hit;
  logic [31:0]               rd_data;

  ch_cfg_t     cfg_a;
  ch_cfg_t     cfg_b;
  smp_pair_t   dsp_q;
  logic        ack_q;
  logic        err_q;
  logic [31:0] rdata_q;

  // source mux, then offset add clamped to the sample range
  function automatic sample_t route(input ch_cfg_t cfg, input smp_pair_t adc);
    sample_t                     src;
    logic signed [smp_bits_c:0]  sum;   // one guard bit
    case (cfg.sel)
      src_adc_a: src = adc.a;
      src_adc_b: src = adc.b;
      src_setp:  src = cfg.setp;
      default:   src = '0;
    endcase
    sum = {src[smp_bits_c-1], src} + {cfg.offs[smp_bits_c-1], cfg.offs};
    if (sum[smp_bits_c] != sum[smp_bits_c-1])  // overflow
      return sum[smp_bits_c] ? {1'b1, {(smp_bits_c-1){1'b0}}}
                             : {1'b0, {(smp_bits_c-1){1'b1}}};
    return sum[smp_bits_c-1:0];
  endfunction

  assign off = req_i.addr[reg_off_bits_c-1:0];
  assign stb = req_i.wen | req_i.ren;

  //////////////////////////////////////////////////
  // register readback

  always_comb
  begin
    hit     = 1'b1;
    rd_data = '0;
    case (off)
      dsp_sel_a_off_c:  rd_data = {30'b0, cfg_a.sel};
      dsp_sel_b_off_c:  rd_data = {30'b0, cfg_b.sel};
      dsp_offs_a_off_c: rd_data = {{pad_c{1'b0}}, cfg_a.offs};
      dsp_offs_b_off_c: rd_data = {{pad_c{1'b0}}, cfg_b.offs};
      dsp_setp_a_off_c: rd_data = {{pad_c{1'b0}}, cfg_a.setp};
      dsp_setp_b_off_c: rd_data = {{pad_c{1'b0}}, cfg_b.setp};
      default:          hit = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // config registers and bus response

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      cfg_a <= '{sel: src_zero, offs: '0, setp: '0};
      cfg_b <= '{sel: src_zero, offs: '0, setp: '0};
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end
    else
    begin
      ack_q <= stb;
      err_q <= stb & ~hit;
      if (req_i.wen)
      begin
        case (off)
          dsp_sel_a_off_c:  cfg_a.sel  <= src_sel_t'(req_i.wdata[1:0]);
          dsp_sel_b_off_c:  cfg_b.sel  <= src_sel_t'(req_i.wdata[1:0]);
          dsp_offs_a_off_c: cfg_a.offs <= sample_t'(req_i.wdata[smp_bits_c-1:0]);
          dsp_offs_b_off_c: cfg_b.offs <= sample_t'(req_i.wdata[smp_bits_c-1:0]);
          dsp_setp_a_off_c: cfg_a.setp <= sample_t'(req_i.wdata[smp_bits_c-1:0]);
          dsp_setp_b_off_c: cfg_b.setp <= sample_t'(req_i.wdata[smp_bits_c-1:0]);
          default:          ;  // unmapped, err only
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    rdata_q <= req_i.ren ? rd_data : '0;
  end

  //////////////////////////////////////////////////
  // output stage, one register per channel

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      dsp_q <= '0;
    else
    begin
      dsp_q.a <= route(cfg_a, adc_i);
      dsp_q.b <= route(cfg_b, adc_i);
    end
  end

  assign dsp_o = dsp_q;
  assign rsp_o = '{rdata: rdata_q, err: err_q, ack: ack_q};

endmodule

// ==== src/rp_top.sv ====
module rp_top (
  input  logic                                    adc_clk,
  input  logic                                    rst_n_i,
  input  rp_bus_pkg::sys_req_t                    sys_req_i,
  output rp_bus_pkg::sys_rsp_t                    sys_rsp_o,
  input  logic [rp_analog_pkg::adc_in_bits_c-1:0] adc_dat_a_i,
  input  logic [rp_analog_pkg::adc_in_bits_c-1:0] adc_dat_b_i,
  input  logic [7:0]                              exp_i,
  output rp_analog_pkg::raw_t                     dac_dat_a_o,
  output rp_analog_pkg::raw_t                     dac_dat_b_o,
  output logic [7:0]                              led_o
);

  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  sys_req_t  hk_req;     // region 0
  sys_rsp_t  hk_rsp;
  sys_req_t  dsp_req;    // region 3
  sys_rsp_t  dsp_rsp;
  smp_pair_t adc_smp;    // converted adc, or dsp when looped
  smp_pair_t dsp_smp;
  logic      loop;

  //////////////////////////////////////////////////
  // bus

  rp_bus_decoder i_dec (
    .req_i     (sys_req_i),
    .hk_rsp_i  (hk_rsp),
    .dsp_rsp_i (dsp_rsp),
    .rsp_o     (sys_rsp_o),
    .hk_req_o  (hk_req),
    .dsp_req_o (dsp_req)
  );

  rp_housekeeping i_hk (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .req_i   (hk_req),
    .exp_i   (exp_i),
    .rsp_o   (hk_rsp),
    .led_o   (led_o),
    .loop_o  (loop)
  );

  //////////////////////////////////////////////////
  // data path, adc -> dsp -> dac

  rp_analog i_analog (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_i      (loop),
    .dsp_i       (dsp_smp),
    .adc_o       (adc_smp),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

  rp_dsp_route i_dsp (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .req_i   (dsp_req),
    .adc_i   (adc_smp),
    .rsp_o   (dsp_rsp),
    .dsp_o   (dsp_smp)
  );

endmodule

// ==== sim/rp_checker.sv ====
module rp_checker (
  input  logic                                    adc_clk,
  input  logic                                    rst_n_i,
  input  rp_bus_pkg::sys_req_t                    req_i,
  input  rp_bus_pkg::sys_rsp_t                    rsp_i,
  input  logic [rp_analog_pkg::adc_in_bits_c-1:0] adc_dat_a_i,
  input  logic [rp_analog_pkg::adc_in_bits_c-1:0] adc_dat_b_i,
  input  logic [7:0]                              exp_i,
  input  rp_analog_pkg::raw_t                     dac_dat_a_i,
  input  rp_analog_pkg::raw_t                     dac_dat_b_i,
  input  logic [7:0]                              led_i,
  output int                                      err_cnt_o,
  output int                                      chk_cnt_o
);

  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  int          errs   = 0;
  int          checks = 0;
  logic        valid  = 1'b0;  // model known after first reset edge
  logic        pend   = 1'b0;  // kept slave owes an ack
  logic        pend_err;
  logic [31:0] pend_rdata;

  // register model, index 0 is channel a
  logic [7:0]  led_m;
  logic        loop_m;
  logic [7:0]  exp_m;
  logic [1:0]  sel_m  [2];
  logic [13:0] offs_m [2];
  logic [13:0] setp_m [2];
  // pipeline model, input reg -> dsp reg -> dac reg
  logic [13:0] raw_m  [2];
  int          dsp_m  [2];
  logic [13:0] dac_m  [2];

  assign err_cnt_o = errs;
  assign chk_cnt_o = checks;

  task automatic compare(input string name, input logic [31:0] exp_v, input logic [31:0] got);
    checks++;
    if (got !== exp_v)
    begin
      errs++;
      $display("ERR %s exp %h got %h at %0t", name, exp_v, got, $time);
    end
  endtask

  // all reads see values from before the edge
  always @(posedge adc_clk)
  begin
    logic [2:0]  region;
    logic [7:0]  off;
    logic        kept;
    logic        hit;
    logic [31:0] rd;
    int          adc_v [2];
    int          src;
    int          sum;
    region = req_i.addr[region_lsb_c +: region_bits_c];
    off    = req_i.addr[reg_off_bits_c-1:0];
    kept   = (region == region_hk_c) || (region == region_dsp_c);

    if (valid)
    begin
      compare("dac_dat_a_o", 32'(dac_m[0]), 32'(dac_dat_a_i));
      compare("dac_dat_b_o", 32'(dac_m[1]), 32'(dac_dat_b_i));
      compare("led_o", 32'(led_m), 32'(led_i));
    end

    ////////////////////////////////////////////////////
    // data path, code c means sample 8191 - c
    for (int c = 0; c < 2; c++)
      adc_v[c] = loop_m ? dsp_m[c] : 8191 - int'(raw_m[c]);
    for (int c = 0; c < 2; c++)
    begin
      dac_m[c] = 14'(8191 - dsp_m[c]);   // uses the old dsp value
      case (sel_m[c])
        src_adc_a: src = adc_v[0];
        src_adc_b: src = adc_v[1];
        src_setp:  src = int'($signed(setp_m[c]));
        default:   src = 0;
      endcase
      sum      = src + int'($signed(offs_m[c]));
      dsp_m[c] = sum > 8191 ? 8191 : (sum < -8192 ? -8192 : sum);  // clamp to 14 bits
    end

    if (!rst_n_i)
    begin
      valid  = 1'b1;
      pend   = 1'b0;
      led_m  = '0;
      loop_m = 1'b0;
      for (int c = 0; c < 2; c++)
      begin
        sel_m[c]  = 2'd3;     // src_zero
        offs_m[c] = '0;
        setp_m[c] = '0;
        dsp_m[c]  = 0;
        dac_m[c]  = 14'h1FFF; // code for zero
      end
    end
    else if (valid)
    begin
      ////////////////////////////////////////////////////
      // bus
      if (pend)
      begin
        if (!rsp_i.ack)
        begin
          errs++;
          $display("no ack one cycle after the strobe, addr %h", req_i.addr);
        end
        else
        begin
          compare("rdata", pend_rdata, rsp_i.rdata);
          compare("err", 32'(pend_err), 32'(rsp_i.err));
        end
        pend = 1'b0;
      end
      else if (kept && rsp_i.ack)
      begin
        errs++;
        $display("ack from region %0d with no strobe pending", region);
      end

      if (req_i.wen || req_i.ren)
      begin
        if (kept)
        begin
          hit = 1'b1;
          rd  = '0;
          if (region == region_hk_c)
            case (off)
              hk_id_off_c:   rd = hk_id_c;
              hk_loop_off_c: rd = 32'(loop_m);
              hk_led_off_c:  rd = 32'(led_m);
              hk_exp_off_c:  rd = 32'(exp_m);
              default:       hit = 1'b0;
            endcase
          else
            case (off)
              dsp_sel_a_off_c:  rd = 32'(sel_m[0]);
              dsp_sel_b_off_c:  rd = 32'(sel_m[1]);
              dsp_offs_a_off_c: rd = 32'(offs_m[0]);
              dsp_offs_b_off_c: rd = 32'(offs_m[1]);
              dsp_setp_a_off_c: rd = 32'(setp_m[0]);
              dsp_setp_b_off_c: rd = 32'(setp_m[1]);
              default:          hit = 1'b0;
            endcase
          pend       = 1'b1;
          pend_err   = !hit;
          pend_rdata = req_i.ren ? rd : 32'h0;   // writes return zero
          if (req_i.wen && region == region_hk_c)
            case (off)
              hk_loop_off_c: loop_m = req_i.wdata[0];
              hk_led_off_c:  led_m  = req_i.wdata[7:0];
              default:       ;
            endcase
          else if (req_i.wen)
            case (off)
              dsp_sel_a_off_c:  sel_m[0]  = req_i.wdata[1:0];
              dsp_sel_b_off_c:  sel_m[1]  = req_i.wdata[1:0];
              dsp_offs_a_off_c: offs_m[0] = req_i.wdata[13:0];
              dsp_offs_b_off_c: offs_m[1] = req_i.wdata[13:0];
              dsp_setp_a_off_c: setp_m[0] = req_i.wdata[13:0];
              dsp_setp_b_off_c: setp_m[1] = req_i.wdata[13:0];
              default:          ;
            endcase
        end
        else
        begin
          // empty region answers in the strobe cycle
          compare("ack", 32'd1, 32'(rsp_i.ack));
          compare("rdata", 32'h0, rsp_i.rdata);
          compare("err", 32'h0, 32'(rsp_i.err));
        end
      end
    end

    raw_m[0] = adc_dat_a_i[15:2];  // lsbs dropped
    raw_m[1] = adc_dat_b_i[15:2];
    exp_m    = exp_i;              // readback stage
  end

endmodule

// ==== sim/tb_rp_top.sv ====
module tb_rp_top;

  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  localparam logic [31:0] seed_c      = 32'h6d15_4634;
  localparam int          n_xfer_c    = 60;    // bus transfers of 3 cycles at most
  localparam int          phase_len_c = 400;   // streaming phase length
  localparam int          timeout_c   = 3 * n_xfer_c + 3 * phase_len_c + 620;

  logic        adc_clk;
  logic        rst_n;
  sys_req_t    sys_req;
  sys_rsp_t    sys_rsp;
  logic [15:0] adc_dat_a = '0;
  logic [15:0] adc_dat_b = '0;
  logic [7:0]  exp_pins  = '0;
  raw_t        dac_a;
  raw_t        dac_b;
  logic [7:0]  led;
  int          err_cnt;
  int          chk_cnt;
  int          cycle_cnt = 0;
  logic [31:0] bus_state = seed_c;
  logic [31:0] smp_state = ~seed_c;  // second stream from the inverted seed

  rp_top i_rp_top (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .exp_i       (exp_pins),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b),
    .led_o       (led)
  );

  rp_checker i_checker (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n),
    .req_i       (sys_req),
    .rsp_i       (sys_rsp),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .exp_i       (exp_pins),
    .dac_dat_a_i (dac_a),
    .dac_dat_b_i (dac_b),
    .led_i       (led),
    .err_cnt_o   (err_cnt),
    .chk_cnt_o   (chk_cnt)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] bus_rand();
    bus_state = lcg_step(bus_state);
    return bus_state;
  endfunction

  function automatic logic [31:0] addr_of(input logic [2:0] region, input logic [7:0] off);
    return (32'(region) << region_lsb_c) | 32'(off);
  endfunction

  // writable registers only
  function automatic logic [31:0] pick_reg(input logic [2:0] k);
    case (k)
      3'd0:    return addr_of(region_hk_c, hk_led_off_c);
      3'd1:    return addr_of(region_hk_c, hk_loop_off_c);
      3'd2:    return addr_of(region_dsp_c, dsp_sel_a_off_c);
      3'd3:    return addr_of(region_dsp_c, dsp_sel_b_off_c);
      3'd4:    return addr_of(region_dsp_c, dsp_offs_a_off_c);
      3'd5:    return addr_of(region_dsp_c, dsp_offs_b_off_c);
      3'd6:    return addr_of(region_dsp_c, dsp_setp_a_off_c);
      default: return addr_of(region_dsp_c, dsp_setp_b_off_c);
    endcase
  endfunction

  // one strobe cycle then hold addr until ack
  task automatic bus_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata);
    int   waits;
    logic acked;
    @(negedge adc_clk);
    sys_req = '{addr: addr, wdata: wdata, wen: wr, ren: ~wr};
    @(posedge adc_clk);
    acked = sys_rsp.ack;       // empty regions ack in the strobe cycle
    @(negedge adc_clk);
    sys_req.wen = 1'b0;
    sys_req.ren = 1'b0;
    waits = 0;
    while (!acked && waits < 8)  // bounded wait for ack
    begin
      @(posedge adc_clk);
      acked = sys_rsp.ack;
      waits++;
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    bus_xfer(1'b1, addr, data);
  endtask

  task automatic read_reg(input logic [31:0] addr);
    bus_xfer(1'b0, addr, 32'h0);
  endtask

  initial
  begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;
  end

  always @(posedge adc_clk)
    cycle_cnt++;

  // fresh samples and expansion pins every falling edge
  always @(negedge adc_clk)
  begin
    smp_state = lcg_step(smp_state);
    adc_dat_a = smp_state[31:16];
    smp_state = lcg_step(smp_state);
    adc_dat_b = smp_state[31:16];
    exp_pins  = smp_state[15:8];
  end

  initial
  begin
    wait (cycle_cnt >= timeout_c);
    $display("timeout, run did not finish within %0d cycles", timeout_c);
    $display("tests failed");
    $finish;
  end

  initial
  begin
    logic [31:0] addr;
    logic [31:0] rnd;
    rst_n   = 1'b0;
    sys_req = '0;
    repeat (4) @(posedge adc_clk);
    @(negedge adc_clk);
    rst_n = 1'b1;

    ////////////////////////////////////////////////////
    // reset state and register access
    read_reg(addr_of(region_hk_c, hk_id_off_c));
    for (int i = 0; i < 12; i++)
    begin
      rnd  = bus_rand();
      addr = pick_reg(rnd[31:29]);
      write_reg(addr, bus_rand());
      read_reg(addr);
    end
    write_reg(addr_of(region_hk_c, hk_id_off_c), bus_rand());  // id is read only
    read_reg(addr_of(region_hk_c, hk_id_off_c));
    for (int r = 0; r < 8; r++)
    begin
      rnd = bus_rand();
      if (3'(r) != region_hk_c && 3'(r) != region_dsp_c)
        read_reg(addr_of(3'(r), rnd[7:0]));
    end
    read_reg(addr_of(region_hk_c, 8'h10));    // unmapped offsets
    write_reg(addr_of(region_hk_c, 8'h44), bus_rand());
    read_reg(addr_of(region_dsp_c, 8'h18));
    read_reg(addr_of(region_dsp_c, 8'hFC));
    repeat (3) read_reg(addr_of(region_hk_c, hk_exp_off_c));

    ////////////////////////////////////////////////////
    // streaming phases
    write_reg(addr_of(region_hk_c, hk_loop_off_c), 32'h0);
    write_reg(addr_of(region_dsp_c, dsp_sel_a_off_c), 32'(src_adc_a));
    write_reg(addr_of(region_dsp_c, dsp_sel_b_off_c), 32'(src_adc_b));
    write_reg(addr_of(region_dsp_c, dsp_offs_a_off_c), 32'h0);
    write_reg(addr_of(region_dsp_c, dsp_offs_b_off_c), 32'h0);
    repeat (phase_len_c) @(negedge adc_clk);   // passthrough

    write_reg(addr_of(region_dsp_c, dsp_offs_a_off_c), bus_rand());
    write_reg(addr_of(region_dsp_c, dsp_offs_b_off_c), bus_rand());
    write_reg(addr_of(region_dsp_c, dsp_sel_a_off_c), 32'(src_adc_b));
    repeat (phase_len_c) @(negedge adc_clk);   // saturating offsets

    write_reg(addr_of(region_dsp_c, dsp_offs_a_off_c), 32'h0);
    write_reg(addr_of(region_dsp_c, dsp_setp_a_off_c), bus_rand());
    write_reg(addr_of(region_dsp_c, dsp_sel_a_off_c), 32'(src_setp));
    repeat (phase_len_c / 2) @(negedge adc_clk);
    write_reg(addr_of(region_hk_c, hk_loop_off_c), 32'h1);  // dsp a feeds back
    write_reg(addr_of(region_dsp_c, dsp_offs_b_off_c), 32'h0);
    write_reg(addr_of(region_dsp_c, dsp_sel_b_off_c), 32'(src_adc_a));
    repeat (phase_len_c / 2) @(negedge adc_clk);
    repeat (4) @(negedge adc_clk);

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0 && chk_cnt > 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== list.f ====
src/rp_bus_pkg.sv
src/rp_analog_pkg.sv
src/rp_bus_decoder.sv
src/rp_housekeeping.sv
src/rp_analog.sv
src/rp_dsp_route.sv
src/rp_top.sv
sim/rp_checker.sv
sim/tb_rp_top.sv

// ==== Makefile ====
TOP := tb_rp_top

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -f list.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module rp_top

clean:
	rm -rf obj_dir
